// ==== cpu_macros.svh ====
/*
  core-wide constants
    reset program counter
    register count
    HALT opcode value
*/
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// first fetch address after reset
`define CPU_PC_INIT 32'h0000_0000
// architectural registers, r0 included
`define CPU_NREGS   32
// HALT sits at the top of the opcode space
`define CPU_HALT_OP 6'b111111

`endif

// ==== cpu_types_pkg.sv ====
/*
  ISA types for the MIPS subset
    word and register index types
    opcode and R-type function enums
    ALU operation enum
*/
`include "cpu_macros.svh"

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // kept opcodes only, R-type is zero
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = `CPU_HALT_OP
  } opcode_t;

  // R-type function field
  typedef enum logic [5:0] {
    SLL  = 6'h00,
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2a
  } funct_t;

  // ALU_ADD is zero so a cleared bundle is an add
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL
  } alu_op_t;

endpackage

// ==== pipe_types_pkg.sv ====
/*
  pipeline types
    control bundle from decode
    fetch/decode, decode/execute, execute/memory and
    memory/writeback stage payloads
*/
package pipe_types_pkg;

  // all zero is a bubble
  typedef struct packed {
    logic reg_wr;
    logic mem_rd;
    logic mem_wr;
    logic mem_to_reg;
    logic alu_src;
    logic reg_dst;
    logic ext_op;
    logic beq;
    logic bne;
    logic jump;
    logic jal;
    logic jr;
    logic lui;
    logic halt;
    cpu_types_pkg::alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    cpu_types_pkg::word_t instr;
    cpu_types_pkg::word_t pc_plus4;
  } fd_t;

  typedef struct packed {
    ctrl_t                ctrl;
    cpu_types_pkg::word_t rdat1;
    cpu_types_pkg::word_t rdat2;
    cpu_types_pkg::word_t ext_imm;
    cpu_types_pkg::word_t instr;
    cpu_types_pkg::word_t pc_plus4;
  } de_t;

  typedef struct packed {
    ctrl_t                    ctrl;
    cpu_types_pkg::word_t     alu_out;
    cpu_types_pkg::word_t     rdat2;
    cpu_types_pkg::reg_addr_t wsel;
    logic [15:0]              imm;
    cpu_types_pkg::word_t     pc_plus4;
  } em_t;

  typedef struct packed {
    ctrl_t                    ctrl;
    cpu_types_pkg::word_t     alu_out;
    cpu_types_pkg::word_t     load_data;
    cpu_types_pkg::reg_addr_t wsel;
    logic [15:0]              imm;
    cpu_types_pkg::word_t     pc_plus4;
  } mw_t;

endpackage

// ==== datapath_cache_if.sv ====
/*
  datapath to cache-side interface
    instruction fetch request and return
    data request and return, halt flag
*/
`timescale 1ns/1ps

interface datapath_cache_if;
  import cpu_types_pkg::*;

  // instruction side
  logic  imem_ren, ihit;
  word_t imem_addr, imem_load;
  // data side, request held until dhit
  logic  dmem_ren, dmem_wen, dhit;
  word_t dmem_addr, dmem_store, dmem_load;
  logic  halt;

  modport dp (
    input  ihit, imem_load, dhit, dmem_load,
    output imem_ren, imem_addr, dmem_ren, dmem_wen, dmem_addr, dmem_store, halt
  );
  modport cache (
    input  imem_ren, imem_addr, dmem_ren, dmem_wen, dmem_addr, dmem_store, halt,
    output ihit, imem_load, dhit, dmem_load
  );
endinterface

// ==== register_file_if.sv ====
/*
  register file interface
    two read ports, one write port
*/
`timescale 1ns/1ps

interface register_file_if;
  import cpu_types_pkg::*;

  reg_addr_t rsel1, rsel2, wsel;
  logic      wen;
  word_t     wdat, rdat1, rdat2;

  modport dp (input rdat1, rdat2, output rsel1, rsel2, wen, wsel, wdat);
  modport rf (input rsel1, rsel2, wen, wsel, wdat, output rdat1, rdat2);
endinterface

// ==== alu.sv ====
/*
  combinational ALU
    add, sub, and, or, signed slt, sll
    zero flag for branch compare
*/
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::word_t   port_a,
  input  cpu_types_pkg::word_t   port_b,
  input  cpu_types_pkg::alu_op_t op,
  output cpu_types_pkg::word_t   result,
  output logic                   zero
);
  import cpu_types_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      // signed compare, result is 0 or 1
      ALU_SLT: result = {31'b0, $signed(port_a) < $signed(port_b)};
      // shift amount from low five bits only
      ALU_SLL: result = port_a << port_b[4:0];
      default: result = '0;
    endcase
  end

  // beq/bne compare via subtract
  assign zero = (result == '0);

endmodule

// ==== control_unit.sv ====
/*
  instruction decoder
    opcode and function field to control bundle
    register, immediate and shift fields
*/
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::word_t     instr,
  output pipe_types_pkg::ctrl_t    ctrl,
  output cpu_types_pkg::reg_addr_t rs,
  output cpu_types_pkg::reg_addr_t rt,
  output cpu_types_pkg::reg_addr_t rd,
  output logic [15:0]              imm,
  output logic [4:0]               shamt
);
  import cpu_types_pkg::*;

  opcode_t op;
  funct_t  fn;

  assign op    = opcode_t'(instr[31:26]);
  assign fn    = funct_t'(instr[5:0]);
  assign rs    = instr[25:21];
  assign rt    = instr[20:16];
  assign rd    = instr[15:11];
  assign imm   = instr[15:0];
  assign shamt = instr[10:6];

  always_comb begin
    ctrl = '0;
    case (op)
      RTYPE: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = 1'b1;
        case (fn)
          ADDU: ctrl.alu_op = ALU_ADD;
          SUBU: ctrl.alu_op = ALU_SUB;
          AND:  ctrl.alu_op = ALU_AND;
          OR:   ctrl.alu_op = ALU_OR;
          SLT:  ctrl.alu_op = ALU_SLT;
          // shamt arrives on the B port
          SLL: begin
            ctrl.alu_op  = ALU_SLL;
            ctrl.alu_src = 1'b1;
          end
          // jr writes nothing
          JR: begin
            ctrl.reg_wr  = 1'b0;
            ctrl.reg_dst = 1'b0;
            ctrl.jr      = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      ADDIU: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.ext_op  = 1'b1;
      end
      // ori zero-extends
      ORI: begin
        ctrl.reg_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op  = ALU_OR;
      end
      LUI: begin
        ctrl.reg_wr = 1'b1;
        ctrl.lui    = 1'b1;
      end
      LW: begin
        ctrl.reg_wr     = 1'b1;
        ctrl.mem_rd     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.ext_op     = 1'b1;
      end
      SW: begin
        ctrl.mem_wr  = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.ext_op  = 1'b1;
      end
      BEQ, BNE: begin
        ctrl.beq    = (op == BEQ);
        ctrl.bne    = (op == BNE);
        ctrl.ext_op = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      J: ctrl.jump = 1'b1;
      // link into r31 picked in execute
      JAL: begin
        ctrl.jal    = 1'b1;
        ctrl.reg_wr = 1'b1;
      end
      HALT: ctrl.halt = 1'b1;
      default: ctrl = '0;
    endcase
  end

  // a load and a store never share one slot
  a_mem_excl: assert final (!(ctrl.mem_rd && ctrl.mem_wr));

endmodule

// ==== register_file.sv ====
/*
  register file
    31 writable registers, r0 reads zero
    write-to-read bypass on both ports
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module register_file (
  input logic CLK,
  input logic nRST,
  register_file_if.rf rfif
);
  import cpu_types_pkg::*;

  // r0 has no storage
  word_t regs [1:`CPU_NREGS-1];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int i = 1; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rfif.wen && (rfif.wsel != '0)) begin
      regs[rfif.wsel] <= rfif.wdat;
    end
  end

  function automatic word_t read_port(input reg_addr_t sel);
    word_t val;
    if (sel == '0) begin
      val = '0;
    end else if (rfif.wen && (rfif.wsel == sel)) begin
      // writeback value seen by decode this cycle
      val = rfif.wdat;
    end else begin
      val = regs[sel];
    end
    return val;
  endfunction

  always_comb begin
    rfif.rdat1 = read_port(rfif.rsel1);
    rfif.rdat2 = read_port(rfif.rsel2);
  end

  // bypass must not leak a write to r0, now or later
  a_r0_zero: assert property (@(posedge CLK) disable iff (!nRST)
    (rfif.wen && rfif.wsel == '0) |-> ##[0:1] (rfif.rsel1 != '0 || rfif.rdat1 == '0));

endmodule

// ==== pipe_reg.sv ====
/*
  stage register for any payload type
    enable to load, flush to insert a bubble
    flush wins over enable
*/
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic CLK,
  input  logic nRST,
  input  logic en,
  input  logic flush,
  input  T     in,
  output T     out
);

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out <= '0;
    end else if (flush) begin
      // zero payload carries no control bits
      out <= '0;
    end else if (en) begin
      out <= in;
    end
  end

endmodule

// ==== datapath.sv ====
/*
  five-stage datapath
    PC and next-PC select, stage registers
    stall, flush and memory freeze
    extenders, write register and writeback muxes
    sticky halt latch
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module datapath (
  input logic CLK,
  input logic nRST,
  datapath_cache_if.dp dpif
);
  import cpu_types_pkg::*;
  import pipe_types_pkg::*;

  word_t pc, pc_plus4, pc_target;
  logic  pc_en;

  fd_t  fd_in, fd_out;
  de_t  de_in, de_out;
  em_t  em_in, em_out;
  mw_t  mw_in, mw_out;
  logic stage_en, fd_en, fd_flush, de_flush;

  ctrl_t       dec_ctrl;
  reg_addr_t   dec_rs, dec_rt;
  logic [15:0] dec_imm;
  logic [4:0]  dec_shamt;
  logic        dec_sll, use_rs, use_rt;

  word_t     alu_b, alu_out;
  logic      alu_zero;
  reg_addr_t ex_wsel;

  logic  freeze, take, raw_stall, ex_dst, mem_dst;
  logic  fetch_ok, fetch_stop;
  word_t wb_data;

  register_file_if rfif ();

  control_unit u_control_unit (
    .instr (fd_out.instr),
    .ctrl  (dec_ctrl),
    .rs    (dec_rs),
    .rt    (dec_rt),
    .rd    (),
    .imm   (dec_imm),
    .shamt (dec_shamt)
  );
  register_file u_register_file (.CLK(CLK), .nRST(nRST), .rfif(rfif.rf));
  alu u_alu (
    .port_a (de_out.rdat1),
    .port_b (alu_b),
    .op     (de_out.ctrl.alu_op),
    .result (alu_out),
    .zero   (alu_zero)
  );

  pipe_reg #(.T(fd_t)) u_fd_reg (.CLK(CLK), .nRST(nRST), .en(fd_en), .flush(fd_flush),
                                 .in(fd_in), .out(fd_out));
  pipe_reg #(.T(de_t)) u_de_reg (.CLK(CLK), .nRST(nRST), .en(stage_en), .flush(de_flush),
                                 .in(de_in), .out(de_out));
  pipe_reg #(.T(em_t)) u_em_reg (.CLK(CLK), .nRST(nRST), .en(stage_en), .flush(1'b0),
                                 .in(em_in), .out(em_out));
  pipe_reg #(.T(mw_t)) u_mw_reg (.CLK(CLK), .nRST(nRST), .en(stage_en), .flush(1'b0),
                                 .in(mw_in), .out(mw_out));

  // ------------------------------------------------------------
  // hazard control
  // ------------------------------------------------------------
  // data access waiting on dhit holds everything
  assign freeze = (em_out.ctrl.mem_rd || em_out.ctrl.mem_wr) && !dpif.dhit;
  // branch or jump resolved in execute
  assign take = (de_out.ctrl.beq && alu_zero) || (de_out.ctrl.bne && !alu_zero) ||
                de_out.ctrl.jump || de_out.ctrl.jal || de_out.ctrl.jr;

  // valid destinations in execute and memory, r0 ignored
  assign ex_dst  = de_out.ctrl.reg_wr && (ex_wsel != '0);
  assign mem_dst = em_out.ctrl.reg_wr && (em_out.wsel != '0);
  // no forwarding, writeback covered by the bypass
  assign raw_stall =
    (use_rs && ((ex_dst && ex_wsel == rfif.rsel1) || (mem_dst && em_out.wsel == rfif.rsel1))) ||
    (use_rt && ((ex_dst && ex_wsel == rfif.rsel2) || (mem_dst && em_out.wsel == rfif.rsel2)));

  // no fetch past a decoded HALT
  assign dpif.imem_ren = !(fetch_stop || dec_ctrl.halt);
  assign fetch_ok      = dpif.ihit && dpif.imem_ren;

  assign stage_en = !freeze;
  assign pc_en    = !freeze && (take || (!raw_stall && fetch_ok));
  assign fd_en    = !freeze && !raw_stall;
  // a missing instruction becomes a bubble
  assign fd_flush = !freeze && (take || (!raw_stall && !fetch_ok));
  assign de_flush = !freeze && (take || raw_stall);

  // ------------------------------------------------------------
  // fetch
  // ------------------------------------------------------------
  assign pc_plus4       = pc + 32'd4;
  assign dpif.imem_addr = pc;
  assign fd_in.instr    = dpif.imem_load;
  assign fd_in.pc_plus4 = pc_plus4;

  always_comb begin
    if (de_out.ctrl.jr) begin
      pc_target = de_out.rdat1;
    end else if (de_out.ctrl.jump || de_out.ctrl.jal) begin
      pc_target = {de_out.pc_plus4[31:28], de_out.instr[25:0], 2'b00};
    end else begin
      pc_target = de_out.pc_plus4 + {de_out.ext_imm[29:0], 2'b00};
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      pc <= `CPU_PC_INIT;
    end else if (pc_en) begin
      pc <= take ? pc_target : pc_plus4;
    end
  end

  // ------------------------------------------------------------
  // decode
  // ------------------------------------------------------------
  // sll shifts rt, so rt goes out on read port 1
  assign dec_sll     = (dec_ctrl.alu_op == ALU_SLL);
  assign rfif.rsel1  = dec_sll ? dec_rt : dec_rs;
  assign rfif.rsel2  = dec_rt;
  assign use_rs      = !(dec_ctrl.jump || dec_ctrl.jal || dec_ctrl.lui);
  assign use_rt      = (!dec_ctrl.alu_src && (dec_ctrl.reg_dst || dec_ctrl.beq || dec_ctrl.bne)) ||
                       dec_ctrl.mem_wr;

  always_comb begin
    de_in.ctrl     = dec_ctrl;
    de_in.rdat1    = rfif.rdat1;
    de_in.rdat2    = rfif.rdat2;
    de_in.instr    = fd_out.instr;
    de_in.pc_plus4 = fd_out.pc_plus4;
    // shamt, sign or zero extension
    if (dec_sll) begin
      de_in.ext_imm = {27'b0, dec_shamt};
    end else if (dec_ctrl.ext_op) begin
      de_in.ext_imm = {{16{dec_imm[15]}}, dec_imm};
    end else begin
      de_in.ext_imm = {16'b0, dec_imm};
    end
  end

  // ------------------------------------------------------------
  // execute and memory
  // ------------------------------------------------------------
  assign alu_b = de_out.ctrl.alu_src ? de_out.ext_imm : de_out.rdat2;

  // rd, rt or r31 for the link
  always_comb begin
    if (de_out.ctrl.jal) begin
      ex_wsel = 5'd31;
    end else if (de_out.ctrl.reg_dst) begin
      ex_wsel = de_out.instr[15:11];
    end else begin
      ex_wsel = de_out.instr[20:16];
    end
  end

  assign em_in.ctrl     = de_out.ctrl;
  assign em_in.alu_out  = alu_out;
  assign em_in.rdat2    = de_out.rdat2;
  assign em_in.wsel     = ex_wsel;
  assign em_in.imm      = de_out.instr[15:0];
  assign em_in.pc_plus4 = de_out.pc_plus4;

  // request stays up while em is frozen
  assign dpif.dmem_ren   = em_out.ctrl.mem_rd;
  assign dpif.dmem_wen   = em_out.ctrl.mem_wr;
  assign dpif.dmem_addr  = em_out.alu_out;
  assign dpif.dmem_store = em_out.rdat2;

  assign mw_in.ctrl      = em_out.ctrl;
  assign mw_in.alu_out   = em_out.alu_out;
  assign mw_in.load_data = dpif.dmem_load;
  assign mw_in.wsel      = em_out.wsel;
  assign mw_in.imm       = em_out.imm;
  assign mw_in.pc_plus4  = em_out.pc_plus4;

  // ------------------------------------------------------------
  // writeback and halt
  // ------------------------------------------------------------
  always_comb begin
    if (mw_out.ctrl.lui) begin
      wb_data = {mw_out.imm, 16'h0000};
    end else if (mw_out.ctrl.jal) begin
      wb_data = mw_out.pc_plus4;
    end else if (mw_out.ctrl.mem_to_reg) begin
      wb_data = mw_out.load_data;
    end else begin
      wb_data = mw_out.alu_out;
    end
  end

  assign rfif.wen  = mw_out.ctrl.reg_wr;
  assign rfif.wsel = mw_out.wsel;
  assign rfif.wdat = wb_data;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      fetch_stop <= 1'b0;
      dpif.halt  <= 1'b0;
    end else begin
      // HALT has left decode for good
      if (dec_ctrl.halt && !freeze && !take && !raw_stall) begin
        fetch_stop <= 1'b1;
      end
      dpif.halt <= dpif.halt || mw_out.ctrl.halt;
    end
  end

  // held data request keeps its address and data
  a_dreq_stable: assert property (@(posedge CLK) disable iff (!nRST)
    freeze |=> $stable(dpif.dmem_addr) && $stable(dpif.dmem_store));

  // a transfer seen during a freeze is still pending after it
  a_no_flush_frozen: assert property (@(posedge CLK) disable iff (!nRST)
    (take && freeze) |=> take && $stable(pc_target) && $stable(pc));

endmodule

// ==== pipeline_cpu.sv ====
/*
  processor top level
    plain memory-side ports onto the cache interface
*/
`timescale 1ns/1ps

module pipeline_cpu (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imem_load,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmem_load,
  output logic                 imem_ren,
  output cpu_types_pkg::word_t imem_addr,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output cpu_types_pkg::word_t dmem_addr,
  output cpu_types_pkg::word_t dmem_store,
  output logic                 halt
);

  datapath_cache_if dpif ();

  datapath u_datapath (.CLK(CLK), .nRST(nRST), .dpif(dpif.dp));

  // returns from memory
  assign dpif.ihit      = ihit;
  assign dpif.imem_load = imem_load;
  assign dpif.dhit      = dhit;
  assign dpif.dmem_load = dmem_load;

  // requests to memory
  assign imem_ren   = dpif.imem_ren;
  assign imem_addr  = dpif.imem_addr;
  assign dmem_ren   = dpif.dmem_ren;
  assign dmem_wen   = dpif.dmem_wen;
  assign dmem_addr  = dpif.dmem_addr;
  assign dmem_store = dpif.dmem_store;
  assign halt       = dpif.halt;

endmodule

// ==== tb_pipeline_cpu.sv ====
/*
  testbench for the pipelined core
    instruction and data memory model with ihit gaps and dhit delays
    instruction encoders and small test programs
    sequential ISA reference model
    store list and final memory compare with a per-test timeout
*/
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_pipeline_cpu;
  import cpu_types_pkg::*;

  logic  CLK = 1'b0;
  logic  nRST = 1'b0;
  logic  ihit = 1'b0;
  logic  dhit = 1'b0;
  word_t imem_load, dmem_load;
  logic  imem_ren, dmem_ren, dmem_wen, halt;
  word_t imem_addr, dmem_addr, dmem_store;

  word_t  imem [0:255];
  word_t  dmem [0:255];
  word_t  ref_mem [0:255];
  word_t  exp_addr[$], exp_data[$];
  word_t  dut_addr[$], dut_data[$];
  integer seed = 32'he015_4734;
  int     dwait = 0;
  int     prog_len, errors = 0, checks = 0;
  bit     gaps_on = 1'b0;
  bit     timed_out = 1'b0;
  string  cur_test;

  pipeline_cpu u_pipeline_cpu (
    .CLK(CLK), .nRST(nRST),
    .ihit(ihit), .imem_load(imem_load), .dhit(dhit), .dmem_load(dmem_load),
    .imem_ren(imem_ren), .imem_addr(imem_addr),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_addr(dmem_addr), .dmem_store(dmem_store), .halt(halt)
  );

  always #20 CLK = ~CLK;

  // ------------------------------------------------------------
  // memory model
  // ------------------------------------------------------------
  // read data follows the word address
  assign imem_load = imem[imem_addr[9:2]];
  assign dmem_load = dmem[dmem_addr[9:2]];

  always @(posedge CLK) begin
    if (!nRST) begin
      ihit  <= 1'b0;
      dhit  <= 1'b0;
      dwait <= 0;
    end else begin
      // about one fetch in four misses when gaps are on
      ihit <= gaps_on ? (($random(seed) & 3) != 0) : 1'b1;
      if (dhit) begin
        // access completes at this edge
        dhit  <= 1'b0;
        dwait <= gaps_on ? ($random(seed) & 3) : 0;
        if (dmem_wen) begin
          dmem[dmem_addr[9:2]] <= dmem_store;
          dut_addr.push_back(dmem_addr);
          dut_data.push_back(dmem_store);
        end
      end else if (dmem_ren || dmem_wen) begin
        if (dwait == 0) begin
          dhit <= 1'b1;
        end else begin
          dwait <= dwait - 1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // encoders and programs
  // ------------------------------------------------------------
  function automatic word_t r_format(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                     logic [4:0] rd, logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t i_format(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                     logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t j_format(logic [5:0] op, logic [25:0] target);
    return {op, target};
  endfunction

  // every bit of the index shows up in the word
  function automatic word_t fill_word(int i);
    return (i * 32'h0001_0003) ^ 32'hc3a5_0000;
  endfunction

  task automatic put(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // zero words are sll r0 nops
  task automatic begin_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = '0;
    end
    prog_len = 0;
  endtask

  // dependent chain with every result stored
  task automatic arith_program();
    begin_program();
    put(i_format(LUI, 5'd0, 5'd1, 16'h1234));
    put(i_format(ORI, 5'd1, 5'd1, 16'h5678));
    put(i_format(ADDIU, 5'd0, 5'd2, 16'hfffd));
    put(r_format(ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
    put(r_format(SUBU, 5'd1, 5'd2, 5'd4, 5'd0));
    put(r_format(AND, 5'd3, 5'd4, 5'd5, 5'd0));
    put(r_format(OR, 5'd5, 5'd2, 5'd6, 5'd0));
    put(r_format(SLT, 5'd2, 5'd1, 5'd7, 5'd0));
    put(r_format(SLT, 5'd1, 5'd2, 5'd8, 5'd0));
    put(r_format(SLL, 5'd0, 5'd1, 5'd9, 5'd4));
    for (int r = 3; r <= 9; r++) begin
      put(i_format(SW, 5'd0, 5'(r), 16'((r - 3) * 4)));
    end
    put(j_format(HALT, 26'd0));
  endtask

  // load-use right behind each lw
  task automatic load_program();
    begin_program();
    put(i_format(LW, 5'd0, 5'd1, 16'd8));
    put(r_format(ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
    put(i_format(SW, 5'd0, 5'd2, 16'd32));
    put(i_format(ADDIU, 5'd0, 5'd3, 16'd16));
    put(i_format(LW, 5'd3, 5'd4, 16'd4));
    put(i_format(LW, 5'd3, 5'd5, 16'd0));
    put(r_format(SUBU, 5'd4, 5'd5, 5'd6, 5'd0));
    put(i_format(SW, 5'd0, 5'd6, 16'd36));
    put(i_format(SW, 5'd3, 5'd4, 16'hfffc));
    put(j_format(HALT, 26'd0));
  endtask

  // taken and not-taken beq/bne with stores in the shadow
  task automatic branch_program();
    begin_program();
    put(i_format(ADDIU, 5'd0, 5'd1, 16'd5));
    put(i_format(ADDIU, 5'd0, 5'd2, 16'd5));
    put(i_format(ADDIU, 5'd0, 5'd3, 16'd7));
    put(i_format(BEQ, 5'd1, 5'd2, 16'd2));
    put(i_format(SW, 5'd0, 5'd1, 16'd0));
    put(i_format(SW, 5'd0, 5'd2, 16'd4));
    put(i_format(SW, 5'd0, 5'd3, 16'd8));
    put(i_format(BNE, 5'd1, 5'd2, 16'd1));
    put(i_format(SW, 5'd0, 5'd1, 16'd12));
    put(i_format(BEQ, 5'd1, 5'd3, 16'd1));
    put(i_format(SW, 5'd0, 5'd2, 16'd16));
    put(i_format(BNE, 5'd1, 5'd3, 16'd2));
    put(i_format(SW, 5'd0, 5'd3, 16'd20));
    put(i_format(SW, 5'd0, 5'd3, 16'd24));
    put(i_format(SW, 5'd0, 5'd1, 16'd28));
    put(j_format(HALT, 26'd0));
  endtask

  // jal out, store the link, jr back, then j forward
  task automatic jump_program();
    begin_program();
    put(i_format(ADDIU, 5'd0, 5'd1, 16'd9));
    put(j_format(JAL, 26'd5));
    put(i_format(SW, 5'd0, 5'd1, 16'd0));
    put(j_format(J, 26'd8));
    put(i_format(SW, 5'd0, 5'd1, 16'd4));
    put(i_format(SW, 5'd0, 5'd31, 16'd8));
    put(i_format(ADDIU, 5'd1, 5'd1, 16'd1));
    put(r_format(JR, 5'd31, 5'd0, 5'd0, 5'd0));
    put(i_format(SW, 5'd0, 5'd1, 16'd12));
    put(j_format(HALT, 26'd0));
  endtask

  // ------------------------------------------------------------
  // reference model stepping one instruction at a time
  // ------------------------------------------------------------
  function automatic int cpu_model();
    word_t      regs [0:31];
    word_t      pc, ins, a, b, simm, zimm, ea;
    logic [5:0] op, fn;
    logic [4:0] rs, rt, rd, sh;
    int         steps;
    bit         done;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      ref_mem[i] = fill_word(i);
    end
    exp_addr.delete();
    exp_data.delete();
    pc    = `CPU_PC_INIT;
    steps = 0;
    done  = 1'b0;
    // bounded so a bad program cannot spin forever
    while (!done && steps < 1000) begin
      ins  = imem[pc[9:2]];
      op   = ins[31:26];
      fn   = ins[5:0];
      rs   = ins[25:21];
      rt   = ins[20:16];
      rd   = ins[15:11];
      sh   = ins[10:6];
      a    = regs[rs];
      b    = regs[rt];
      simm = {{16{ins[15]}}, ins[15:0]};
      zimm = {16'h0000, ins[15:0]};
      ea   = a + simm;
      pc   = pc + 32'd4;
      steps++;
      case (op)
        RTYPE: begin
          case (fn)
            ADDU: regs[rd] = a + b;
            SUBU: regs[rd] = a - b;
            AND:  regs[rd] = a & b;
            OR:   regs[rd] = a | b;
            SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLL:  regs[rd] = b << sh;
            JR:   pc = a;
            default: ;
          endcase
        end
        ADDIU: regs[rt] = a + simm;
        ORI:   regs[rt] = a | zimm;
        LUI:   regs[rt] = {ins[15:0], 16'h0000};
        LW:    regs[rt] = ref_mem[ea[9:2]];
        SW: begin
          ref_mem[ea[9:2]] = b;
          exp_addr.push_back(ea);
          exp_data.push_back(b);
        end
        // no delay slot so the offset counts from pc + 4
        BEQ: if (a == b) pc = pc + (simm << 2);
        BNE: if (a != b) pc = pc + (simm << 2);
        J:   pc = {pc[31:28], ins[25:0], 2'b00};
        JAL: begin
          regs[31] = pc;
          pc       = {pc[31:28], ins[25:0], 2'b00};
        end
        HALT: done = 1'b1;
        default: ;
      endcase
      regs[0] = '0;
    end
    return steps;
  endfunction

  // ------------------------------------------------------------
  // checks and run control
  // ------------------------------------------------------------
  task automatic check_value(input string what, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_reset_outputs(input string when);
    check_value({when, " halt"}, 32'd0, halt);
    check_value({when, " dmem_ren"}, 32'd0, dmem_ren);
    check_value({when, " dmem_wen"}, 32'd0, dmem_wen);
    check_value({when, " imem_ren"}, 32'd1, imem_ren);
    check_value({when, " imem_addr"}, `CPU_PC_INIT, imem_addr);
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  task automatic run_program(input string name, input bit gaps);
    int n_model, limit, cycles;
    if (!timed_out) begin
      cur_test = name;
      @(posedge CLK);
      nRST    <= 1'b0;
      gaps_on <= gaps;
      dut_addr.delete();
      dut_data.delete();
      for (int i = 0; i < 256; i++) begin
        dmem[i] = fill_word(i);
      end
      n_model = cpu_model();
      limit   = 10 * n_model + 200;
      repeat (15) @(posedge CLK);
      @(negedge CLK);
      check_reset_outputs("in reset");
      @(posedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      check_reset_outputs("after reset");
      cycles = 0;
      while (!halt && cycles < limit) begin
        @(negedge CLK);
        cycles++;
      end
      if (!halt) begin
        errors++;
        timed_out = 1'b1;
        $display("%s: halt never rose within %0d cycles, run stopped", name, limit);
      end else begin
        // halt must stay up with fetch and the data side quiet
        repeat (20) begin
          @(negedge CLK);
          check_value("halt held", 32'd1, halt);
          check_value("imem_ren after halt", 32'd0, imem_ren);
          check_value("dmem request after halt", 32'd0, {dmem_ren, dmem_wen});
        end
        check_value("store count", exp_addr.size(), dut_addr.size());
        for (int i = 0; i < exp_addr.size() && i < dut_addr.size(); i++) begin
          check_value($sformatf("store %0d addr", i), exp_addr[i], dut_addr[i]);
          check_value($sformatf("store %0d data", i), exp_data[i], dut_data[i]);
        end
        for (int i = 0; i < 256; i++) begin
          check_value($sformatf("dmem[%0d]", i), ref_mem[i], dmem[i]);
        end
      end
    end
  endtask

  initial begin
    // first pass with an ideal memory and then with gaps
    arith_program();
    run_program("arith_no_gaps", 1'b0);
    arith_program();
    run_program("arith", 1'b1);
    load_program();
    run_program("loads", 1'b1);
    branch_program();
    run_program("branches", 1'b1);
    jump_program();
    run_program("jumps", 1'b1);
    finish_run();
  end

endmodule

// ==== files.f ====
+incdir+.
cpu_types_pkg.sv
pipe_types_pkg.sv
datapath_cache_if.sv
register_file_if.sv
alu.sv
control_unit.sv
register_file.sv
pipe_reg.sv
datapath.sv
pipeline_cpu.sv
tb_pipeline_cpu.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

export_include_dirs:
  - .

sources:
  - cpu_types_pkg.sv
  - pipe_types_pkg.sv
  - datapath_cache_if.sv
  - register_file_if.sv
  - alu.sv
  - control_unit.sv
  - register_file.sv
  - pipe_reg.sv
  - datapath.sv
  - pipeline_cpu.sv
  - target: simulation
    files:
      - tb_pipeline_cpu.sv
